// ==== src.f ====
vc_pkg.sv
vc_head_if.sv
vc_input_port.sv
vc_sa_local.sv
vc_sa_global.sv
vc_credit_counter.sv
vc_router.sv
tb_vc_router.sv

// ==== run.sh ====
#!/bin/sh
# build and run the vc_router testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f src.f \
  --top-module tb_vc_router -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
  echo "result: pass"
  exit 0
fi
echo "result: fail, see sim.log"
exit 1

// ==== tb_vc_router.sv ====
// random traffic from a fixed seed checked against a reference model of vc_router
// the upstream and downstream routers are modelled here and driven on the falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_vc_router;
  import vc_pkg::*;

  logic                                clk;
  logic                                rst;
  logic [NUM_PORTS-1:0]                data_v_i;
  flit_t [NUM_PORTS-1:0]               data_i;
  logic [NUM_PORTS-1:0]                credit_v_o;
  logic [NUM_PORTS-1:0][VC_W-1:0]      credit_id_o;
  logic [NUM_PORTS-1:0]                credit_v_i;
  logic [NUM_PORTS-1:0][VC_W-1:0]      credit_id_i;
  logic [NUM_PORTS-1:0]                data_v_o;
  flit_t [NUM_PORTS-1:0]               data_o;

  // ======================================================================
  // model state
  // ======================================================================

  // expected flits per (source, vc, destination)
  flit_t           exp_q [NUM_PORTS*NUM_VC*NUM_PORTS][$];
  // unreturned downstream credits per output, in arrival order
  logic [VC_W-1:0] pend_q [NUM_PORTS][$];
  int              up_cred  [NUM_PORTS][NUM_VC];
  int              dn_out   [NUM_PORTS][NUM_VC];
  int              seq      [NUM_PORTS][NUM_VC];
  // grants on output 0 since each input last won
  int              gap [NUM_PORTS];
  logic [31:0]     rng_state;
  int              send_pct;
  int              ret_pct;
  bit              traffic_on;
  bit              hold;
  bit              sat_mode;
  bit              sat_check;
  bit              timed_out;
  int              err_flit;
  int              err_credit;
  int              err_other;

  vc_router vc_router_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i),
    .data_v_o    (data_v_o),
    .data_o      (data_o)
  );

  always #50 clk = ~clk;

  // lcg step returning the upper bits
  function automatic int unsigned next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return int'(rng_state >> 8);
  endfunction

  function automatic int rand_pct();
    return int'(next_rand() % 100);
  endfunction

  function automatic int qidx(input int src, input int vc, input int dst);
    return (src * NUM_VC + vc) * NUM_PORTS + dst;
  endfunction

  // nothing in flight and no credit owed in either direction
  function automatic bit router_idle();
    for (int k = 0; k < NUM_PORTS * NUM_VC * NUM_PORTS; k++) begin
      if (exp_q[k].size() != 0) return 1'b0;
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (pend_q[p].size() != 0) return 1'b0;
      for (int v = 0; v < NUM_VC; v++) begin
        if (up_cred[p][v] != VC_DEPTH) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      err_flit++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_credit(input string name, input logic [VC_W-1:0] got,
                              input logic [VC_W-1:0] exp);
    if (got !== exp) begin
      err_credit++;
      $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // ======================================================================
  // output monitor and downstream side
  // ======================================================================

  task automatic monitor_outputs();
    flit_t           f;
    int              src;
    int              k;
    logic            exp_cv  [NUM_PORTS];
    logic [VC_W-1:0] exp_cid [NUM_PORTS];
    for (int p = 0; p < NUM_PORTS; p++) begin
      exp_cv[p]  = 1'b0;
      exp_cid[p] = '0;
    end
    if (!traffic_on && (data_v_o !== '0 || credit_v_o !== '0)) begin
      err_other++;
      $display("output activity at %0t before any traffic was sent", $time);
    end
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (data_v_o[o] === 1'b1) begin
        f   = data_o[o];
        src = int'(f.payload[PAYLOAD_W-1]);
        k   = qidx(src, int'(f.vc_id), o);
        if (exp_q[k].size() == 0) begin
          err_flit++;
          $display("unexpected flit %h on output %0d at %0t", f, o, $time);
        end else begin
          check_flit($sformatf("data_o[%0d]", o), f, exp_q[k].pop_front());
        end
        // the pop behind this flit returns a credit to its source now
        exp_cv[src]  = 1'b1;
        exp_cid[src] = f.vc_id;
        dn_out[o][f.vc_id]++;
        if (dn_out[o][f.vc_id] > VC_DEPTH) begin
          err_other++;
          $display("output %0d VC %0d sent past its downstream credit at %0t", o, f.vc_id, $time);
        end
        pend_q[o].push_back(f.vc_id);
        // round-robin bound on the saturated output
        if (sat_check && o == 0) begin
          for (int i = 0; i < NUM_PORTS; i++) begin
            gap[i] = (i == src) ? 0 : gap[i] + 1;
            if (gap[i] >= NUM_PORTS) begin
              err_other++;
              $display("input %0d starved on output 0 at %0t", i, $time);
            end
          end
        end
      end
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (credit_v_o[p] !== exp_cv[p]) begin
        err_credit++;
        $display("error at %0t: credit_v_o[%0d] got %b expected %b",
                 $time, p, credit_v_o[p], exp_cv[p]);
      end else if (exp_cv[p]) begin
        check_credit($sformatf("credit_id_o[%0d]", p), credit_id_o[p], exp_cid[p]);
        up_cred[p][credit_id_o[p]]++;
        if (up_cred[p][credit_id_o[p]] > VC_DEPTH) begin
          err_credit++;
          $display("input %0d VC %0d returned more than %0d credits at %0t",
                   p, credit_id_o[p], VC_DEPTH, $time);
        end
      end
    end
  endtask

  // ======================================================================
  // stimulus with downstream credits first and upstream flits after
  // ======================================================================

  task automatic drive_inputs();
    int              v0;
    int              vv;
    int              pick;
    flit_t           f;
    logic [VC_W-1:0] cv;
    for (int o = 0; o < NUM_PORTS; o++) begin
      credit_v_i[o]  = 1'b0;
      credit_id_i[o] = '0;
      // hold models a stalled downstream router
      if (!hold && pend_q[o].size() > 0 && rand_pct() < ret_pct) begin
        cv             = pend_q[o].pop_front();
        credit_v_i[o]  = 1'b1;
        credit_id_i[o] = cv;
        dn_out[o][cv]--;
      end
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      data_v_i[p] = 1'b0;
      data_i[p]   = '0;
      if (rand_pct() < send_pct) begin
        v0   = int'(next_rand() % NUM_VC);
        pick = -1;
        for (int i = 0; i < NUM_VC; i++) begin
          vv = (v0 + i) % NUM_VC;
          if (pick < 0 && up_cred[p][vv] > 0) pick = vv;
        end
        // upstream only sends while holding a credit
        if (pick >= 0) begin
          f.vc_id     = VC_W'(pick);
          f.dst       = sat_mode ? PORT_0 : port_e'(PORT_W'(next_rand() % NUM_PORTS));
          // source in the top bit and sequence number below
          f.payload   = {PORT_W'(p), 15'(seq[p][pick])};
          data_v_i[p] = 1'b1;
          data_i[p]   = f;
          exp_q[qidx(p, pick, int'(f.dst))].push_back(f);
          up_cred[p][pick]--;
          seq[p][pick]++;
        end
      end
    end
  endtask

  always @(negedge clk) begin
    monitor_outputs();
    drive_inputs();
  end

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (!router_idle() && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    if (!router_idle()) begin
      timed_out = 1'b1;
      err_other++;
      $display("timeout at %0t: router did not drain within %0d cycles", $time, max_cycles);
    end
  endtask

  task automatic finish_run();
    $display("errors: flit %0d, credit %0d, other %0d", err_flit, err_credit, err_other);
    if (err_flit + err_credit + err_other == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // ======================================================================
  // test sequence
  // ======================================================================

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    rng_state   = 32'h20e1_5c96;
    send_pct    = 0;
    ret_pct     = 0;
    traffic_on  = 1'b0;
    hold        = 1'b0;
    sat_mode    = 1'b0;
    sat_check   = 1'b0;
    timed_out   = 1'b0;
    err_flit    = 0;
    err_credit  = 0;
    err_other   = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      gap[p] = 0;
      for (int v = 0; v < NUM_VC; v++) begin
        up_cred[p][v]  = VC_DEPTH;
        dn_out[p][v]   = 0;
        seq[p][v]      = 0;
      end
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // quiet period with outputs held low
    repeat (5) @(posedge clk);
    traffic_on = 1'b1;
    send_pct   = 70;
    ret_pct    = 50;
    repeat (300) @(posedge clk);
    // downstream stalls so every output VC stops at VC_DEPTH
    hold = 1'b1;
    repeat (60) @(posedge clk);
    hold = 1'b0;
    repeat (100) @(posedge clk);
    send_pct = 0;
    wait_drain(1000);
    if (!timed_out) begin
      // both inputs flood output 0 while credits come back at once
      sat_mode = 1'b1;
      ret_pct  = 100;
      send_pct = 100;
      repeat (12) @(posedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
        gap[p] = 0;
      end
      sat_check = 1'b1;
      repeat (200) @(posedge clk);
      sat_check = 1'b0;
      send_pct  = 0;
      wait_drain(1000);
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== vc_router.sv ====
// two-port credit-based VC router top, flits keep their VC index
// one flit per output per cycle, leaves one cycle after its grant
`timescale 1ns/1ps
`default_nettype none

module vc_router (
  input  wire logic                                       clk_i,
  input  wire logic                                       rst_i,
  // input side links
  input  wire logic          [vc_pkg::NUM_PORTS-1:0]      data_v_i,
  input  wire vc_pkg::flit_t [vc_pkg::NUM_PORTS-1:0]      data_i,
  output logic               [vc_pkg::NUM_PORTS-1:0]      credit_v_o,
  output logic [vc_pkg::NUM_PORTS-1:0][vc_pkg::VC_W-1:0]  credit_id_o,
  // output side links
  input  wire logic          [vc_pkg::NUM_PORTS-1:0]      credit_v_i,
  input  wire logic [vc_pkg::NUM_PORTS-1:0][vc_pkg::VC_W-1:0] credit_id_i,
  output logic               [vc_pkg::NUM_PORTS-1:0]      data_v_o,
  output vc_pkg::flit_t      [vc_pkg::NUM_PORTS-1:0]      data_o
);
  import vc_pkg::*;

  // request matrix, [input][output]
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0]           sa_req;
  // transposed, [output][input]
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0]           req_per_out;
  logic [NUM_PORTS-1:0][VC_W-1:0]                sa_req_vc;
  logic [NUM_PORTS-1:0]                          win;
  logic [NUM_PORTS-1:0]                          grant_v;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0]           grant;
  logic [NUM_PORTS-1:0][PORT_W-1:0]              sel_in;
  logic [NUM_PORTS-1:0]                          consume_v;
  logic [NUM_PORTS-1:0][VC_W-1:0]                consume_id;
  logic [NUM_PORTS-1:0][NUM_VC-1:0][CNT_W-1:0]   credit_cnt;
  // head flit of the VC each input put forward
  flit_t [NUM_PORTS-1:0]                         sel_flit;

  vc_head_if hd_if [NUM_PORTS] ();

  // ======================================================================
  // per input: buffers and local allocation
  // ======================================================================

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_in
    vc_input_port vc_input_port_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p]),
      .hd          (hd_if[p])
    );

    vc_sa_local vc_sa_local_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .hd           (hd_if[p]),
      .credit_cnt_i (credit_cnt),
      .req_o        (sa_req[p]),
      .req_vc_o     (sa_req_vc[p]),
      .win_i        (win[p])
    );

    // a global grant pops the VC that local allocation chose
    assign hd_if[p].pop    = win[p];
    assign hd_if[p].pop_vc = sa_req_vc[p];
    assign sel_flit[p]     = hd_if[p].head[sa_req_vc[p]];
  end

  // ======================================================================
  // per output: global allocation and credit tracking
  // ======================================================================

  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        req_per_out[o][i] = sa_req[i][o];
      end
    end
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out
    vc_sa_global vc_sa_global_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (req_per_out[o]),
      .grant_v_o (grant_v[o]),
      .grant_o   (grant[o])
    );

    vc_credit_counter vc_credit_counter_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .credit_v_i   (credit_v_i[o]),
      .credit_id_i  (credit_id_i[o]),
      .consume_v_i  (consume_v[o]),
      .consume_id_i (consume_id[o]),
      .credit_cnt_o (credit_cnt[o])
    );
  end

  // one-hot grant to index, win back to inputs
  always_comb begin
    win = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      sel_in[o] = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (grant[o][i]) begin
          sel_in[o] = PORT_W'(i);
          win[i]    = 1'b1;
        end
      end
      // same VC index downstream, so the granted VC is the one consumed
      consume_v[o]  = grant_v[o];
      consume_id[o] = sa_req_vc[sel_in[o]];
    end
  end

  // ======================================================================
  // switch traversal registers
  // ======================================================================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_v_o <= '0;
    end else begin
      data_v_o <= grant_v;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      data_o[o] <= sel_flit[sel_in[o]];
    end
  end

endmodule

`default_nettype wire

// ==== vc_credit_counter.sv ====
// free downstream slots per VC of one output, reset to VC_DEPTH
// a consume on an empty counter is not caught, allocation must prevent it
`timescale 1ns/1ps
`default_nettype none

module vc_credit_counter (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  // credit returned by the downstream router
  input  wire logic                    credit_v_i,
  input  wire logic [vc_pkg::VC_W-1:0] credit_id_i,
  // slot taken by a flit leaving through this output
  input  wire logic                    consume_v_i,
  input  wire logic [vc_pkg::VC_W-1:0] consume_id_i,
  output logic [vc_pkg::NUM_VC-1:0][vc_pkg::CNT_W-1:0] credit_cnt_o
);
  import vc_pkg::*;

  logic [NUM_VC-1:0][CNT_W-1:0] cnt_q;
  logic [NUM_VC-1:0]            inc;
  logic [NUM_VC-1:0]            dec;

  always_comb begin
    for (int v = 0; v < NUM_VC; v++) begin
      inc[v] = credit_v_i && (credit_id_i == VC_W'(v));
      dec[v] = consume_v_i && (consume_id_i == VC_W'(v));
    end
  end

  // return and consume on the same VC cancel out
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int v = 0; v < NUM_VC; v++) begin
        cnt_q[v] <= CNT_W'(VC_DEPTH);
      end
    end else begin
      for (int v = 0; v < NUM_VC; v++) begin
        if (inc[v] && !dec[v]) begin
          cnt_q[v] <= cnt_q[v] + 1'b1;
        end else if (dec[v] && !inc[v]) begin
          cnt_q[v] <= cnt_q[v] - 1'b1;
        end
      end
    end
  end

  // a credit landing at edge K is visible to allocation after edge K
  assign credit_cnt_o = cnt_q;

endmodule

`default_nettype wire

// ==== vc_sa_global.sv ====
// global switch allocation for one output port
// round-robin over requesting inputs, pointer moves past each winner
`timescale 1ns/1ps
`default_nettype none

module vc_sa_global (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  // one request bit per input port
  input  wire logic [vc_pkg::NUM_PORTS-1:0] req_i,
  output logic                         grant_v_o,
  // one-hot winning input
  output logic [vc_pkg::NUM_PORTS-1:0] grant_o
);
  import vc_pkg::*;

  // input checked first
  logic [PORT_W-1:0] ptr_q;
  logic [PORT_W-1:0] win_idx;

  // scan from the pointer, first requester wins
  always_comb begin
    int unsigned idx;
    grant_v_o = 1'b0;
    grant_o   = '0;
    win_idx   = ptr_q;
    for (int i = 0; i < NUM_PORTS; i++) begin
      idx = (int'(ptr_q) + i) % NUM_PORTS;
      if (!grant_v_o && req_i[idx]) begin
        grant_v_o    = 1'b1;
        grant_o[idx] = 1'b1;
        win_idx      = PORT_W'(idx);
      end
    end
  end

  // winner drops to lowest priority
  // so a steady requester waits at most NUM_PORTS-1 grants
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (grant_v_o) begin
      ptr_q <= (int'(win_idx) == NUM_PORTS - 1) ? '0 : win_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== vc_sa_local.sv ====
// local switch allocation for one input port
// picks one VC whose head has a downstream credit, round-robin over VCs
// the request goes to the head's dst output only
`timescale 1ns/1ps
`default_nettype none

module vc_sa_local (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  // head status of this input port
  vc_head_if.alloc                     hd,
  // free downstream slots per output and VC
  input  wire logic [vc_pkg::NUM_PORTS-1:0][vc_pkg::NUM_VC-1:0][vc_pkg::CNT_W-1:0]
                                       credit_cnt_i,
  // one-hot request towards the global allocators
  output logic [vc_pkg::NUM_PORTS-1:0] req_o,
  // VC behind the request
  output logic [vc_pkg::VC_W-1:0]      req_vc_o,
  // set when some output granted this input
  input  wire logic                    win_i
);
  import vc_pkg::*;

  // rr pointer, the VC checked first
  logic [VC_W-1:0]   ptr_q;
  logic [NUM_VC-1:0] elig;
  logic              any_elig;
  logic [VC_W-1:0]   sel_vc;

  // head present and its (dst, vc) counter nonzero
  always_comb begin
    for (int v = 0; v < NUM_VC; v++) begin
      elig[v] = hd.head_v[v] &&
                (credit_cnt_i[hd.head[v].dst][hd.head[v].vc_id] != '0);
    end
  end

  // first eligible VC at or after the pointer
  always_comb begin
    int unsigned idx;
    any_elig = 1'b0;
    sel_vc   = ptr_q;
    for (int i = 0; i < NUM_VC; i++) begin
      idx = (int'(ptr_q) + i) % NUM_VC;
      if (!any_elig && elig[idx]) begin
        any_elig = 1'b1;
        sel_vc   = VC_W'(idx);
      end
    end
  end

  // request the chosen head's destination
  always_comb begin
    req_o = '0;
    if (any_elig) begin
      req_o[hd.head[sel_vc].dst] = 1'b1;
    end
  end

  assign req_vc_o = sel_vc;

  // move past the winner only once the grant is confirmed,
  // a lost request keeps its priority for the next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (win_i) begin
      ptr_q <= (int'(sel_vc) == NUM_VC - 1) ? '0 : sel_vc + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== vc_input_port.sv ====
// per-VC flit buffers of one input port, VC_DEPTH flits each
// upstream must send only with credit, a push into a full VC is not caught
// credit return is registered one cycle after the pop
`timescale 1ns/1ps
`default_nettype none

module vc_input_port (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  // flit link from upstream
  input  wire logic                    data_v_i,
  input  wire vc_pkg::flit_t           data_i,
  // credit link back upstream
  output logic                         credit_v_o,
  output logic [vc_pkg::VC_W-1:0]      credit_id_o,
  // head status and pop command
  vc_head_if.port                      hd
);
  import vc_pkg::*;

  // ======================================================================
  // storage and pointers
  // ======================================================================

  flit_t            mem_q    [NUM_VC][VC_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q [NUM_VC];
  logic [PTR_W-1:0] rd_ptr_q [NUM_VC];
  // number of flits held per VC
  logic [CNT_W-1:0] fill_q   [NUM_VC];

  logic [NUM_VC-1:0] push;
  logic [NUM_VC-1:0] pop;

  // circular pointer step, wraps at VC_DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(VC_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // decode arriving flit and pop command per VC
  always_comb begin
    for (int v = 0; v < NUM_VC; v++) begin
      push[v] = data_v_i && (data_i.vc_id == VC_W'(v));
      pop[v]  = hd.pop && (hd.pop_vc == VC_W'(v));
    end
  end

  // flit storage, written at the VC's write pointer
  always_ff @(posedge clk_i) begin
    if (data_v_i) begin
      mem_q[data_i.vc_id][wr_ptr_q[data_i.vc_id]] <= data_i;
    end
  end

  // pointer and fill bookkeeping
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int v = 0; v < NUM_VC; v++) begin
        wr_ptr_q[v] <= '0;
        rd_ptr_q[v] <= '0;
        fill_q[v]   <= '0;
      end
    end else begin
      for (int v = 0; v < NUM_VC; v++) begin
        if (push[v]) begin
          wr_ptr_q[v] <= ptr_inc(wr_ptr_q[v]);
        end
        if (pop[v]) begin
          rd_ptr_q[v] <= ptr_inc(rd_ptr_q[v]);
        end
        // push and pop in one cycle leave the fill level unchanged
        fill_q[v] <= fill_q[v] + CNT_W'(push[v]) - CNT_W'(pop[v]);
      end
    end
  end

  // ======================================================================
  // head presentation and credit return
  // ======================================================================

  // a flit written at edge N is a valid head right after edge N
  always_comb begin
    for (int v = 0; v < NUM_VC; v++) begin
      hd.head_v[v] = (fill_q[v] != '0);
      hd.head[v]   = mem_q[v][rd_ptr_q[v]];
    end
  end

  // one freed slot per pop goes back upstream
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_v_o <= 1'b0;
    end else begin
      credit_v_o <= hd.pop;
    end
  end

  // id only meaningful while credit_v_o is high
  always_ff @(posedge clk_i) begin
    credit_id_o <= hd.pop_vc;
  end

endmodule

`default_nettype wire

// ==== vc_head_if.sv ====
// head status of one input port towards its allocator, plus the pop command
// pop is only legal for a VC whose head_v bit is set
`timescale 1ns/1ps
`default_nettype none

interface vc_head_if;
  import vc_pkg::*;

  // one valid bit per VC buffer
  logic [NUM_VC-1:0] head_v;
  // oldest flit of each VC buffer
  flit_t [NUM_VC-1:0] head;
  // pop strobe and the VC it applies to
  logic pop;
  logic [VC_W-1:0] pop_vc;

  // buffer side presents heads and takes pops
  modport port (
    output head_v,
    output head,
    input  pop,
    input  pop_vc
  );

  // allocation side looks at heads and issues pops
  modport alloc (
    input  head_v,
    input  head,
    output pop,
    output pop_vc
  );

endinterface

`default_nettype wire

// ==== vc_pkg.sv ====
// shared sizes and flit format for the two-port credit-based VC router
// routing is the dst field only, a flit keeps its vc_id through the router
`default_nettype none

package vc_pkg;

  // ======================================================================
  // router sizes
  // ======================================================================

  // input and output ports
  localparam int NUM_PORTS = 2;
  // port index width
  localparam int PORT_W = 1;
  // virtual channels per port
  localparam int NUM_VC = 2;
  localparam int VC_W = 1;
  // flits per VC buffer, equal to the reset credit count
  localparam int VC_DEPTH = 2;
  // read/write pointer width inside one VC buffer
  localparam int PTR_W = 1;
  // credit counter holds 0 .. VC_DEPTH
  localparam int CNT_W = 2;
  localparam int PAYLOAD_W = 16;

  // ======================================================================
  // flit format
  // ======================================================================

  // destination output of a flit
  typedef enum logic [PORT_W-1:0] {
    PORT_0 = 1'b0,
    PORT_1 = 1'b1
  } port_e;

  // 18 bit flit, header fields on top
  typedef struct packed {
    logic [VC_W-1:0]      vc_id;
    port_e                dst;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

endpackage

`default_nettype wire
